//--- build.f
wb_bus_pkg.sv
wb_arb_pkg.sv
wb_arb.sv
wb_master_mux.sv
wb_sram.sv
wb_host_top.sv
tb_wb_host.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run the simulation, then search the log for the pass message
verilator --binary --timing --assert --top-module tb_wb_host -f build.f -o tb_wb_host \
   > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_wb_host > sim.log 2>&1
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- tb_wb_host.sv
/*
 * Self-checking testbench for the Wishbone shared-bus host block.
 * Three master models share the SRAM while a reference arbiter and a
 * reference memory predict the grant, every ack and all read data.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_wb_host;

   import wb_bus_pkg::*;
   import wb_arb_pkg::*;

   //////////////////////////////////////////////////
   // Test sizes and run limit
   //////////////////////////////////////////////////

   // Words written by the single master and later reused as targets
   localparam int N_TAB = 48;
   // Sessions per master and transfers per session in the contention test
   localparam int N_SESS = 5;
   localparam int N_HOLD = 4;
   // Partial write test length
   localparam int N_PART = 64;
   // Twice the time of about 300 transfers at up to 6 cycles each plus reset
   localparam int MAX_CYCLES = 300 * 6 * 2 + 400;

   logic    clk;
   logic    rstn;
   wb_req_t m_req [N_MST];
   wb_rsp_t m_rsp [N_MST];
   grant_e  gnt;

   // Reference memory written in the order the bus completes writes
   logic [31:0] ref_mem [MEM_WORDS];
   logic [7:0]  addr_tab [N_TAB];
   logic [15:0] lfsr = 16'd87;
   grant_e      exp_gnt = GNT_M0;
   int          last_ack_m = 0;
   int          cycles = 0;
   int          gnt_errs = 0;
   int          hs_errs = 0;
   int          data_errs = 0;

   // Pre-drawn stimulus for the three concurrent masters
   logic [31:0] st_adr [N_MST][N_SESS*N_HOLD];
   logic [31:0] st_dat [N_MST][N_SESS*N_HOLD];
   logic [3:0]  st_sel [N_MST][N_SESS*N_HOLD];
   logic        st_we  [N_MST][N_SESS*N_HOLD];

   wb_host_top UUT (
      .clk   (clk),
      .rstn  (rstn),
      .m_req (m_req),
      .m_rsp (m_rsp),
      .gnt   (gnt)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Reference models
   //////////////////////////////////////////////////

   // 16-bit Fibonacci LFSR with taps 16 14 13 11 and one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      logic        fb;
      int          k;
      r = '0;
      for (k = 0; k < n; k++) begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic logic [31:0] word_adr(input logic [7:0] idx);
      return {22'd0, idx, 2'b00};
   endfunction

   // The owner keeps the bus while it requests
   // Otherwise the first requester after it in rotating order wins
   // With no requester the grant stays parked
   function automatic grant_e next_grant(input grant_e prev, input logic [2:0] cyc);
      int p;
      int c;
      int k;
      p = int'(prev);
      if (cyc[p]) begin
         return prev;
      end
      for (k = 1; k < N_MST; k++) begin
         c = (p + k) % N_MST;
         if (cyc[c]) begin
            return grant_e'(c);
         end
      end
      return prev;
   endfunction

   // Merge a write into the reference memory byte by byte
   task automatic mirror_write(input wb_req_t r);
      int b;
      for (b = 0; b < WB_SW; b++) begin
         if (r.sel[b]) begin
            ref_mem[r.adr[9:2]][b*8 +: 8] = r.dat[b*8 +: 8];
         end
      end
   endtask

   //////////////////////////////////////////////////
   // Master models
   //////////////////////////////////////////////////

   // One classic transfer that is called and returns on a falling edge
   // The request stays unchanged through the ack cycle and stb drops in
   // the cycle after it unless the caller presents a new transfer there
   task automatic bus_transfer(input int m, input logic w, input logic [31:0] adr,
                               input logic [3:0] sel, input logic [31:0] dat,
                               input logic chk_lat);
      int waits;
      waits = 0;
      m_req[m] = '{cyc: 1'b1, stb: 1'b1, we: w, adr: adr, sel: sel, dat: dat};
      @(negedge clk);
      waits++;
      while (!m_rsp[m].ack) begin
         @(negedge clk);
         waits++;
      end
      // An owner that already holds the grant gets ack one cycle on
      if (chk_lat) begin
         assert (waits == 1) else begin
            $display("FAIL ack latency of master %0d: got 0x%0h, expected 0x1", m, waits);
            hs_errs++;
         end
      end
      // The ack is taken on the rising edge that ends the ack cycle
      @(negedge clk);
      m_req[m].stb = 1'b0;
      m_req[m].we  = 1'b0;
   endtask

   task automatic release_bus(input int m);
      m_req[m] = '0;
   endtask

   // Contention traffic that holds cyc for a few transfers and then drops it
   task automatic run_sessions(input int m);
      int s;
      int k;
      int j;
      for (s = 0; s < N_SESS; s++) begin
         for (k = 0; k < N_HOLD; k++) begin
            j = s * N_HOLD + k;
            bus_transfer(m, st_we[m][j], st_adr[m][j], st_sel[m][j], st_dat[m][j], 1'b0);
         end
         release_bus(m);
         @(negedge clk);
      end
   endtask

   //////////////////////////////////////////////////
   // Checking processes
   //////////////////////////////////////////////////

   // Grant against the reference arbiter on every rising edge
   always @(posedge clk) begin : grant_check
      logic [2:0] cyc_vec;
      cyc_vec = {m_req[2].cyc, m_req[1].cyc, m_req[0].cyc};
      if (!rstn) begin
         exp_gnt <= GNT_M0;
      end else begin
         assert (gnt == exp_gnt) else begin
            $display("FAIL gnt: got 0x%0h, expected 0x%0h", gnt, exp_gnt);
            gnt_errs++;
         end
         exp_gnt <= next_grant(exp_gnt, cyc_vec);
      end
   end

   // Acks and read data
   // An access accepted on one edge must be acked in the following
   // cycle and only to the master that made it
   always @(posedge clk) begin : data_check
      logic    pend_valid;
      int      pend_m;
      wb_req_t pend_req;
      logic    exp_ack;
      int      i;
      int      gi;
      if (!rstn) begin
         pend_valid = 1'b0;
      end else begin
         for (i = 0; i < N_MST; i++) begin
            exp_ack = pend_valid && (pend_m == i);
            assert (m_rsp[i].ack == exp_ack) else begin
               $display("FAIL m_rsp[%0d].ack: got 0x%0h, expected 0x%0h",
                        i, m_rsp[i].ack, exp_ack);
               hs_errs++;
            end
            if (exp_ack && !pend_req.we) begin
               assert (m_rsp[i].dat == ref_mem[pend_req.adr[9:2]]) else begin
                  $display("FAIL m_rsp[%0d].dat: got 0x%08h, expected 0x%08h",
                           i, m_rsp[i].dat, ref_mem[pend_req.adr[9:2]]);
                  data_errs++;
               end
            end
            // Masters off the bus see no read data at all
            if (int'(exp_gnt) != i) begin
               assert (m_rsp[i].dat == '0) else begin
                  $display("FAIL m_rsp[%0d].dat: got 0x%08h, expected 0x0", i, m_rsp[i].dat);
                  data_errs++;
               end
            end
         end
         if (pend_valid) begin
            last_ack_m = pend_m;
            if (pend_req.we) begin
               mirror_write(pend_req);
            end
         end
         // No new access starts in an ack cycle
         gi = int'(exp_gnt);
         if (!pend_valid && m_req[gi].cyc && m_req[gi].stb) begin
            pend_valid = 1'b1;
            pend_m     = gi;
            pend_req   = m_req[gi];
         end else begin
            pend_valid = 1'b0;
         end
      end
   end

   // Watchdog
   initial begin : watchdog
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
   end

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin : main
      int m;
      int k;
      int own;
      int wr_m;
      int rd_m;
      for (m = 0; m < N_MST; m++) begin
         m_req[m] = '0;
      end
      rstn = 1'b0;
      repeat (8) @(negedge clk);
      rstn = 1'b1;
      @(negedge clk);

      // After reset the grant is on master 0 and no master sees ack
      assert (gnt == GNT_M0) else begin
         $display("FAIL gnt after reset: got 0x%0h, expected 0x0", gnt);
         gnt_errs++;
      end
      for (m = 0; m < N_MST; m++) begin
         assert (m_rsp[m].ack == 1'b0) else begin
            $display("FAIL m_rsp[%0d].ack after reset: got 0x%0h, expected 0x0",
                     m, m_rsp[m].ack);
            hs_errs++;
         end
      end

      // A single master writes full words and reads them back
      for (k = 0; k < N_TAB; k++) begin
         addr_tab[k] = 8'(rand_bits(8));
      end
      for (k = 0; k < N_TAB; k++) begin
         bus_transfer(0, 1'b1, word_adr(addr_tab[k]), 4'hF, rand_bits(32), 1'b1);
      end
      for (k = 0; k < N_TAB; k++) begin
         bus_transfer(0, 1'b0, word_adr(addr_tab[k]), 4'hF, 32'h0, 1'b1);
      end
      release_bus(0);
      @(negedge clk);

      // All three masters contend for words that were already written
      for (m = 0; m < N_MST; m++) begin
         for (k = 0; k < N_SESS * N_HOLD; k++) begin
            st_adr[m][k] = word_adr(addr_tab[int'(rand_bits(6)) % N_TAB]);
            st_dat[m][k] = rand_bits(32);
            st_sel[m][k] = 4'(rand_bits(4));
            st_we[m][k]  = rand_bits(1) != 0;
         end
      end
      fork
         run_sessions(0);
         run_sessions(1);
         run_sessions(2);
      join

      // On an idle bus the grant parks on the last owner and serves it at once
      repeat (3) @(negedge clk);
      own = last_ack_m;
      assert (int'(gnt) == own) else begin
         $display("FAIL gnt while parked: got 0x%0h, expected 0x%0h", gnt, own);
         gnt_errs++;
      end
      bus_transfer(own, 1'b1, word_adr(addr_tab[0]), 4'hF, rand_bits(32), 1'b1);
      bus_transfer(own, 1'b0, word_adr(addr_tab[0]), 4'hF, 32'h0, 1'b1);
      release_bus(own);
      @(negedge clk);

      // Partial writes from one master are read back by another
      wr_m = (own + 1) % N_MST;
      rd_m = (own + 2) % N_MST;
      for (k = 0; k < N_PART; k++) begin
         bus_transfer(wr_m, 1'b1, word_adr(addr_tab[k % N_TAB]), 4'(rand_bits(4)),
                      rand_bits(32), 1'b0);
      end
      release_bus(wr_m);
      @(negedge clk);
      for (k = 0; k < N_PART; k++) begin
         bus_transfer(rd_m, 1'b0, word_adr(addr_tab[k % N_TAB]), 4'hF, 32'h0, 1'b0);
      end
      release_bus(rd_m);
      repeat (2) @(negedge clk);

      $display("Errors: grant %0d, handshake %0d, data %0d, total %0d",
               gnt_errs, hs_errs, data_errs, gnt_errs + hs_errs + data_errs);
      if (gnt_errs + hs_errs + data_errs == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- wb_arb.sv
/*
 * Round-robin Wishbone arbiter for three masters.
 * The owner keeps the bus while its cyc is high; when it lets go the
 * grant passes to the next requester in rotating order, and with no
 * requests at all the grant stays parked at the last owner.
 */

`timescale 1ns/1ps
`default_nettype none

module wb_arb (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic [wb_arb_pkg::N_MST-1:0]  req,
   output wb_arb_pkg::grant_e            gnt
);

   import wb_arb_pkg::*;

   // Current owner and the owner for the next cycle
   grant_e state;
   grant_e state_nxt;

   // The grant is the state register itself, so it changes one
   // cycle after the request pattern that justifies it
   assign gnt = state;

   //////////////////////////////////////////////////
   // State register
   //////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         state <= GNT_M0;
      end else begin
         state <= state_nxt;
      end
   end

   //////////////////////////////////////////////////
   // Round-robin next state
   //////////////////////////////////////////////////

   // Each branch first checks the owner, then searches the other two
   // masters starting with the one right after the owner
   always_comb begin
      state_nxt = state;
      case (state)
         GNT_M0: begin
            if (!req[0]) begin
               if (req[1]) begin
                  state_nxt = GNT_M1;
               end else if (req[2]) begin
                  state_nxt = GNT_M2;
               end
            end
         end
         GNT_M1: begin
            if (!req[1]) begin
               if (req[2]) begin
                  state_nxt = GNT_M2;
               end else if (req[0]) begin
                  state_nxt = GNT_M0;
               end
            end
         end
         GNT_M2: begin
            if (!req[2]) begin
               if (req[0]) begin
                  state_nxt = GNT_M0;
               end else if (req[1]) begin
                  state_nxt = GNT_M1;
               end
            end
         end
         // Recover to master 0 should the unused code ever appear
         default: state_nxt = GNT_M0;
      endcase
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // The grant never takes the unused encoding
   a_gnt_legal: assert property (@(posedge clk) disable iff (!rstn)
      state inside {GNT_M0, GNT_M1, GNT_M2});

   // An owner that keeps its request keeps the bus next cycle
   a_owner_kept: assert property (@(posedge clk) disable iff (!rstn)
      req[state] |=> $stable(state));

endmodule

`default_nettype wire

//--- wb_arb_pkg.sv
/*
 * Arbitration definitions for the shared-bus host block.
 * Gives the number of masters and the grant encoding used by the
 * arbiter state register, the master multiplexer and the top level.
 */

`default_nettype none

package wb_arb_pkg;

   // Number of masters sharing the slave
   localparam int N_MST = 3;

   // Grant state, one code per master
   // Code 3 is never reached by the arbiter
   typedef enum logic [1:0] {
      GNT_M0 = 2'd0,
      GNT_M1 = 2'd1,
      GNT_M2 = 2'd2
   } grant_e;

endpackage

`default_nettype wire

//--- wb_bus_pkg.sv
/*
 * Wishbone bus definitions for the shared-bus host block.
 * Holds the classic request and response bundles that travel between
 * the masters, the master multiplexer and the SRAM slave, plus the
 * data widths and the size of the on-chip memory.
 */

`default_nettype none

package wb_bus_pkg;

   //////////////////////////////////////////////////
   // Bus and memory sizes
   //////////////////////////////////////////////////

   // Data bus width in bits
   localparam int WB_DW = 32;
   // One select bit per data byte
   localparam int WB_SW = 4;
   // Word address width of the SRAM, taken from adr[9:2]
   localparam int MEM_AW = 8;
   // Number of 32-bit words held by the SRAM
   localparam int MEM_WORDS = 1 << MEM_AW;

   //////////////////////////////////////////////////
   // Request and response bundles
   //////////////////////////////////////////////////

   // One master's classic Wishbone request
   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [31:0]      adr;  // Byte address
      logic [WB_SW-1:0] sel;
      logic [WB_DW-1:0] dat;  // Write data
   } wb_req_t;

   // Slave response, read data is only meaningful while ack is high
   typedef struct packed {
      logic             ack;
      logic [WB_DW-1:0] dat;
   } wb_rsp_t;

endpackage

`default_nettype wire

//--- wb_host_top.sv
/*
 * Wishbone shared-bus host block.
 * Three masters share one SRAM slave through a round-robin arbiter
 * and a master multiplexer. Only instances and wiring live here.
 */

`timescale 1ns/1ps
`default_nettype none

module wb_host_top (
   input  logic                clk,
   input  logic                rstn,
   input  wb_bus_pkg::wb_req_t m_req [wb_arb_pkg::N_MST],
   output wb_bus_pkg::wb_rsp_t m_rsp [wb_arb_pkg::N_MST],
   output wb_arb_pkg::grant_e  gnt
);

   import wb_bus_pkg::*;
   import wb_arb_pkg::*;

   // Arbiter requests, one cyc bit per master
   logic [N_MST-1:0] arb_req;

   // Bus between the multiplexer and the slave
   wb_req_t s_req;
   wb_rsp_t s_rsp;

   // Each master's cyc doubles as its bus request
   for (genvar i = 0; i < N_MST; i++) begin : g_req
      assign arb_req[i] = m_req[i].cyc;
   end

   wb_arb u_arb (
      .clk  (clk),
      .rstn (rstn),
      .req  (arb_req),
      .gnt  (gnt)
   );

   wb_master_mux u_mux (
      .clk   (clk),
      .rstn  (rstn),
      .gnt   (gnt),
      .m_req (m_req),
      .m_rsp (m_rsp),
      .s_req (s_req),
      .s_rsp (s_rsp)
   );

   wb_sram u_sram (
      .clk  (clk),
      .rstn (rstn),
      .req  (s_req),
      .rsp  (s_rsp)
   );

endmodule

`default_nettype wire

//--- wb_master_mux.sv
/*
 * Wishbone master multiplexer.
 * Forwards the granted master's request to the single slave and hands
 * the slave response back to that master only. All other masters see
 * ack low and zero read data. Purely combinational on the data path.
 */

`timescale 1ns/1ps
`default_nettype none

module wb_master_mux (
   input  logic                clk,
   input  logic                rstn,
   input  wb_arb_pkg::grant_e  gnt,
   input  wb_bus_pkg::wb_req_t m_req [wb_arb_pkg::N_MST],
   output wb_bus_pkg::wb_rsp_t m_rsp [wb_arb_pkg::N_MST],
   output wb_bus_pkg::wb_req_t s_req,
   input  wb_bus_pkg::wb_rsp_t s_rsp
);

   import wb_bus_pkg::*;
   import wb_arb_pkg::*;

   // Per-master ack as seen at the master side, gathered for checking
   logic [N_MST-1:0] ack_vec;

   //////////////////////////////////////////////////
   // Request and response steering
   //////////////////////////////////////////////////

   // Nothing reaches the slave unless a master is named by the grant,
   // so an idle or unused grant code leaves cyc and stb low
   always_comb begin
      s_req = '0;
      for (int i = 0; i < N_MST; i++) begin
         // Responses default to zero for every master
         m_rsp[i] = '0;
         if (gnt == grant_e'(i)) begin
            s_req    = m_req[i];
            m_rsp[i] = s_rsp;
         end
      end
   end

   // Collect the returned acks into one vector
   always_comb begin
      for (int i = 0; i < N_MST; i++) begin
         ack_vec[i] = m_rsp[i].ack;
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // The slave response is never broadcast to more than one master
   a_ack_onehot: assert property (@(posedge clk) disable iff (!rstn)
      $onehot0(ack_vec));

   // A slave ack only reaches a master that is actually on the bus
   a_ack_owner: assert property (@(posedge clk) disable iff (!rstn)
      s_rsp.ack |-> s_req.cyc);

endmodule

`default_nettype wire

//--- wb_sram.sv
/*
 * Wishbone slave SRAM, 256 words of 32 bits.
 * Every access takes one wait state. The ack is registered one cycle
 * after cyc and stb are first seen together and lasts one cycle.
 * Writes honour the byte selects, reads return the addressed word.
 */

`timescale 1ns/1ps
`default_nettype none

module wb_sram (
   input  logic                clk,
   input  logic                rstn,
   input  wb_bus_pkg::wb_req_t req,
   output wb_bus_pkg::wb_rsp_t rsp
);

   import wb_bus_pkg::*;

   // Storage array
   logic [WB_DW-1:0] mem [MEM_WORDS];

   // Word index taken from the byte address
   logic [MEM_AW-1:0] idx;

   // A new access is accepted in the first cycle of cyc and stb
   // The ack cycle itself never starts another one
   logic access;

   // Registered ack and read data
   logic             ack;
   logic [WB_DW-1:0] rdat;

   assign idx    = req.adr[MEM_AW+1:2];
   assign access = req.cyc && req.stb && !ack;

   //////////////////////////////////////////////////
   // Handshake
   //////////////////////////////////////////////////

   // Ack rises one cycle after the strobe and drops right after,
   // which gives back-to-back transfers one idle cycle in between
   always_ff @(posedge clk or negedge rstn) begin
      if (!rstn) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

   //////////////////////////////////////////////////
   // Memory array
   //////////////////////////////////////////////////

   // Writes land on the same edge that raises ack
   always_ff @(posedge clk) begin
      if (access && req.we) begin
         for (int b = 0; b < WB_SW; b++) begin
            // Only bytes with their select bit set are updated
            if (req.sel[b]) begin
               mem[idx][b*8 +: 8] <= req.dat[b*8 +: 8];
            end
         end
      end
   end

   // Read word is captured together with ack so it is valid in the
   // ack cycle
   always_ff @(posedge clk) begin
      if (access) begin
         rdat <= mem[idx];
      end
   end

   assign rsp = '{ack: ack, dat: rdat};

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // One wait state per transfer means ack is never high twice in a row
   a_ack_single: assert property (@(posedge clk) disable iff (!rstn)
      ack |=> !ack);

endmodule

`default_nettype wire
